/* hw/rv32_isa_pkg.sv */
// rv32 isa package with word, register index and major opcode definitions
`default_nettype none

package rv32_isa_pkg;

  localparam int unsigned XLEN = 32;

  typedef logic [XLEN-1:0] word_t;

  // architectural register index
  typedef logic [4:0] reg_addr_t;

  // major opcodes kept by the scalar decoder
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011
  } opcode_t;

  // funct7 of the m extension
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

  // funct7 selecting sub and sra
  localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

endpackage

`default_nettype wire

/* hw/decode_pkg.sv */
// decode stage package with unit selects, alu operations and writeback latencies
`default_nettype none

package decode_pkg;

  // functional unit the instruction is issued to
  typedef enum logic [2:0] {
    FU_NONE = 3'd0,
    FU_ALU  = 3'd1,
    FU_MUL  = 3'd2,
    FU_DIV  = 3'd3,
    FU_LSU  = 3'd4
  } fu_t;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_AND    = 4'd2,
    ALU_OR     = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_SLL    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_SLT    = 4'd8,
    ALU_SLTU   = 4'd9,
    ALU_COPY_B = 4'd10
  } alu_op_t;

  typedef enum logic {
    SRC_A_RS1 = 1'b0,
    SRC_A_PC  = 1'b1
  } src_a_t;

  typedef enum logic [1:0] {
    SRC_B_RS2   = 2'd0,
    SRC_B_IMM_I = 2'd1,
    SRC_B_IMM_S = 2'd2,
    SRC_B_IMM_U = 2'd3
  } src_b_t;

  // writeback reservation window
  localparam int unsigned WB_SLOTS     = 18;
  localparam int unsigned LAT_ALU      = 0;
  localparam int unsigned LAT_MUL      = 3;
  localparam int unsigned LAT_DIV      = 17;
  localparam int unsigned LAT_DIV_FAST = 0;

  // dividend that overflows a signed divide by -1
  localparam rv32_isa_pkg::word_t DIV_MIN_INT = 32'h8000_0000;

endpackage

`default_nettype wire

/* hw/instr_decoder.sv */
// instruction decoder producing unit, alu operation, operand selects and immediates
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
  input  rv32_isa_pkg::word_t     instr,
  output decode_pkg::fu_t         fu,
  output decode_pkg::alu_op_t     alu_op,
  output logic [2:0]              funct3,
  output rv32_isa_pkg::reg_addr_t rs1,
  output rv32_isa_pkg::reg_addr_t rs2,
  output rv32_isa_pkg::reg_addr_t rd,
  output logic                    wen,
  output decode_pkg::src_a_t      src_a_sel,
  output decode_pkg::src_b_t      src_b_sel,
  output rv32_isa_pkg::word_t     imm_i,
  output rv32_isa_pkg::word_t     imm_s,
  output rv32_isa_pkg::word_t     imm_u,
  output logic                    illegal
);

  logic [6:0] funct7;
  decode_pkg::alu_op_t f3_op;
  logic writes_rd;

  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u = {instr[31:12], 12'b0};

  // base alu operation by funct3, alt forms patched below
  always_comb begin
    case (funct3)
      3'b000:  f3_op = decode_pkg::ALU_ADD;
      3'b001:  f3_op = decode_pkg::ALU_SLL;
      3'b010:  f3_op = decode_pkg::ALU_SLT;
      3'b011:  f3_op = decode_pkg::ALU_SLTU;
      3'b100:  f3_op = decode_pkg::ALU_XOR;
      3'b101:  f3_op = decode_pkg::ALU_SRL;
      3'b110:  f3_op = decode_pkg::ALU_OR;
      default: f3_op = decode_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    fu        = decode_pkg::FU_NONE;
    alu_op    = decode_pkg::ALU_ADD;
    src_a_sel = decode_pkg::SRC_A_RS1;
    src_b_sel = decode_pkg::SRC_B_RS2;
    writes_rd = 1'b1;
    illegal   = 1'b0;
    case (rv32_isa_pkg::opcode_t'(instr[6:0]))
      rv32_isa_pkg::OP: begin
        if (funct7 == rv32_isa_pkg::FUNCT7_MULDIV) begin
          // funct3[2] splits multiply from divide/remainder
          fu = funct3[2] ? decode_pkg::FU_DIV : decode_pkg::FU_MUL;
        end else if (funct7 == 7'b0) begin
          fu     = decode_pkg::FU_ALU;
          alu_op = f3_op;
        end else if (funct7 == rv32_isa_pkg::FUNCT7_ALT && funct3 == 3'b000) begin
          fu     = decode_pkg::FU_ALU;
          alu_op = decode_pkg::ALU_SUB;
        end else if (funct7 == rv32_isa_pkg::FUNCT7_ALT && funct3 == 3'b101) begin
          fu     = decode_pkg::FU_ALU;
          alu_op = decode_pkg::ALU_SRA;
        end else begin
          illegal = 1'b1;
        end
      end
      rv32_isa_pkg::OP_IMM: begin
        fu        = decode_pkg::FU_ALU;
        alu_op    = f3_op;
        src_b_sel = decode_pkg::SRC_B_IMM_I;
        // only shift immediates carry a funct7
        if (funct3 == 3'b101 && funct7 == rv32_isa_pkg::FUNCT7_ALT) begin
          alu_op = decode_pkg::ALU_SRA;
        end else if ((funct3 == 3'b001 || funct3 == 3'b101) && funct7 != 7'b0) begin
          illegal = 1'b1;
        end
      end
      rv32_isa_pkg::LUI: begin
        fu        = decode_pkg::FU_ALU;
        alu_op    = decode_pkg::ALU_COPY_B;
        src_b_sel = decode_pkg::SRC_B_IMM_U;
      end
      rv32_isa_pkg::AUIPC: begin
        fu        = decode_pkg::FU_ALU;
        src_a_sel = decode_pkg::SRC_A_PC;
        src_b_sel = decode_pkg::SRC_B_IMM_U;
      end
      rv32_isa_pkg::LOAD: begin
        fu        = decode_pkg::FU_LSU;
        src_b_sel = decode_pkg::SRC_B_IMM_I;
      end
      rv32_isa_pkg::STORE: begin
        fu        = decode_pkg::FU_LSU;
        src_b_sel = decode_pkg::SRC_B_IMM_S;
        writes_rd = 1'b0;
      end
      default: illegal = 1'b1;
    endcase
    if (illegal) begin
      fu = decode_pkg::FU_NONE;
    end
  end

  // x0 is never written
  assign wen = writes_rd & ~illegal & (rd != 5'd0);

endmodule

`default_nettype wire

/* hw/operand_select.sv */
// operand select muxing bypass data, pc and immediates onto the two unit ports
`timescale 1ns/1ps
`default_nettype none

module operand_select (
  input  rv32_isa_pkg::word_t  pc,
  input  decode_pkg::src_a_t   src_a_sel,
  input  decode_pkg::src_b_t   src_b_sel,
  input  rv32_isa_pkg::word_t  imm_i,
  input  rv32_isa_pkg::word_t  imm_s,
  input  rv32_isa_pkg::word_t  imm_u,
  input  rv32_isa_pkg::word_t  rs1_data,
  input  rv32_isa_pkg::word_t  rs2_data,
  input  logic                 rs1_bypass_ena,
  input  rv32_isa_pkg::word_t  rs1_bypass_data,
  input  logic                 rs2_bypass_ena,
  input  rv32_isa_pkg::word_t  rs2_bypass_data,
  output rv32_isa_pkg::word_t  port_a,
  output rv32_isa_pkg::word_t  port_b,
  output rv32_isa_pkg::word_t  store_data
);

  rv32_isa_pkg::word_t rs1_val;
  rv32_isa_pkg::word_t rs2_val;

  // bypass network wins over the register file
  assign rs1_val = rs1_bypass_ena ? rs1_bypass_data : rs1_data;
  assign rs2_val = rs2_bypass_ena ? rs2_bypass_data : rs2_data;

  always_comb begin
    case (src_a_sel)
      decode_pkg::SRC_A_PC: port_a = pc;
      default:              port_a = rs1_val;
    endcase
  end

  always_comb begin
    case (src_b_sel)
      decode_pkg::SRC_B_IMM_I: port_b = imm_i;
      decode_pkg::SRC_B_IMM_S: port_b = imm_s;
      decode_pkg::SRC_B_IMM_U: port_b = imm_u;
      default:                 port_b = rs2_val;
    endcase
  end

  assign store_data = rs2_val;

endmodule

`default_nettype wire

/* hw/wb_slot_tracker.sv */
// writeback slot tracker reserving future writeback cycles and flagging conflicts
`timescale 1ns/1ps
`default_nettype none

module wb_slot_tracker (
  input  logic                CLK,
  input  logic                nRST,
  input  decode_pkg::fu_t     fu,
  input  rv32_isa_pkg::word_t port_a,
  input  rv32_isa_pkg::word_t port_b,
  input  logic                dispatch,
  output logic                conflict
);

  localparam int unsigned N = decode_pkg::WB_SLOTS;

  logic [N-1:0] window;
  logic [N-1:0] need_mask;
  logic         div_special;

  // overflow, divide by -1 and divide by zero finish without iterating
  assign div_special = (port_a == decode_pkg::DIV_MIN_INT) || (port_b == '1) || (port_b == '0);

  // one-hot slot this instruction writes back in, zero when it needs none
  always_comb begin
    case (fu)
      decode_pkg::FU_ALU: need_mask = N'(1) << decode_pkg::LAT_ALU;
      decode_pkg::FU_MUL: need_mask = N'(1) << decode_pkg::LAT_MUL;
      decode_pkg::FU_DIV: begin
        if (div_special) begin
          need_mask = N'(1) << decode_pkg::LAT_DIV_FAST;
        end else begin
          need_mask = N'(1) << decode_pkg::LAT_DIV;
        end
      end
      default: need_mask = '0;
    endcase
  end

  assign conflict = |(window & need_mask);

  // window moves one slot closer every cycle, stalled or not
  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      window <= '0;
    end else if (dispatch) begin
      window <= (window | need_mask) >> 1;
    end else begin
      window <= window >> 1;
    end
  end

endmodule

`default_nettype wire

/* hw/dispatch_latch.sv */
// dispatch register holding the decoded instruction behind a valid/ready handshake
`timescale 1ns/1ps
`default_nettype none

module dispatch_latch (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    in_valid,
  input  logic                    conflict,
  input  logic                    out_ready,
  input  decode_pkg::fu_t         fu,
  input  decode_pkg::alu_op_t     alu_op,
  input  logic [2:0]              funct3,
  input  rv32_isa_pkg::reg_addr_t rd,
  input  logic                    wen,
  input  rv32_isa_pkg::word_t     port_a,
  input  rv32_isa_pkg::word_t     port_b,
  input  rv32_isa_pkg::word_t     store_data,
  input  rv32_isa_pkg::word_t     pc,
  input  logic                    illegal,
  output logic                    in_ready,
  output logic                    dispatch,
  output logic                    out_valid,
  output decode_pkg::fu_t         out_fu,
  output decode_pkg::alu_op_t     out_alu_op,
  output logic [2:0]              out_funct3,
  output rv32_isa_pkg::reg_addr_t out_rd,
  output logic                    out_wen,
  output rv32_isa_pkg::word_t     out_port_a,
  output rv32_isa_pkg::word_t     out_port_b,
  output rv32_isa_pkg::word_t     out_store_data,
  output rv32_isa_pkg::word_t     out_pc,
  output logic                    out_illegal
);

  // room when empty or draining, and the writeback slot is free
  assign in_ready = (~out_valid | out_ready) & ~conflict;
  assign dispatch = in_valid & in_ready;

  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      out_valid <= 1'b0;
    end else if (dispatch) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // payload only moves on accept, so it holds under back-pressure
  always_ff @(posedge CLK) begin
    if (dispatch) begin
      out_fu         <= fu;
      out_alu_op     <= alu_op;
      out_funct3     <= funct3;
      out_rd         <= rd;
      out_wen        <= wen;
      out_port_a     <= port_a;
      out_port_b     <= port_b;
      out_store_data <= store_data;
      out_pc         <= pc;
      out_illegal    <= illegal;
    end
  end

endmodule

`default_nettype wire

/* hw/decode_stage.sv */
// decode stage top connecting decoder, operand select, slot tracker and dispatch register
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    in_valid,
  input  rv32_isa_pkg::word_t     in_instr,
  input  rv32_isa_pkg::word_t     in_pc,
  output logic                    in_ready,
  output rv32_isa_pkg::reg_addr_t rs1_addr,
  output rv32_isa_pkg::reg_addr_t rs2_addr,
  input  rv32_isa_pkg::word_t     rs1_data,
  input  rv32_isa_pkg::word_t     rs2_data,
  input  logic                    rs1_bypass_ena,
  input  rv32_isa_pkg::word_t     rs1_bypass_data,
  input  logic                    rs2_bypass_ena,
  input  rv32_isa_pkg::word_t     rs2_bypass_data,
  output logic                    out_valid,
  output decode_pkg::fu_t         out_fu,
  output decode_pkg::alu_op_t     out_alu_op,
  output logic [2:0]              out_funct3,
  output rv32_isa_pkg::reg_addr_t out_rd,
  output logic                    out_wen,
  output rv32_isa_pkg::word_t     out_port_a,
  output rv32_isa_pkg::word_t     out_port_b,
  output rv32_isa_pkg::word_t     out_store_data,
  output rv32_isa_pkg::word_t     out_pc,
  output logic                    out_illegal,
  input  logic                    out_ready
);

  decode_pkg::fu_t         fu;
  decode_pkg::alu_op_t     alu_op;
  logic [2:0]              funct3;
  rv32_isa_pkg::reg_addr_t rd;
  logic                    wen;
  decode_pkg::src_a_t      src_a_sel;
  decode_pkg::src_b_t      src_b_sel;
  rv32_isa_pkg::word_t     imm_i;
  rv32_isa_pkg::word_t     imm_s;
  rv32_isa_pkg::word_t     imm_u;
  logic                    illegal;
  rv32_isa_pkg::word_t     port_a;
  rv32_isa_pkg::word_t     port_b;
  rv32_isa_pkg::word_t     store_data;
  logic                    conflict;
  logic                    dispatch;

  instr_decoder u_decoder (
    .instr     (in_instr),
    .fu        (fu),
    .alu_op    (alu_op),
    .funct3    (funct3),
    .rs1       (rs1_addr),
    .rs2       (rs2_addr),
    .rd        (rd),
    .wen       (wen),
    .src_a_sel (src_a_sel),
    .src_b_sel (src_b_sel),
    .imm_i     (imm_i),
    .imm_s     (imm_s),
    .imm_u     (imm_u),
    .illegal   (illegal)
  );

  operand_select u_operands (
    .pc              (in_pc),
    .src_a_sel       (src_a_sel),
    .src_b_sel       (src_b_sel),
    .imm_i           (imm_i),
    .imm_s           (imm_s),
    .imm_u           (imm_u),
    .rs1_data        (rs1_data),
    .rs2_data        (rs2_data),
    .rs1_bypass_ena  (rs1_bypass_ena),
    .rs1_bypass_data (rs1_bypass_data),
    .rs2_bypass_ena  (rs2_bypass_ena),
    .rs2_bypass_data (rs2_bypass_data),
    .port_a          (port_a),
    .port_b          (port_b),
    .store_data      (store_data)
  );

  wb_slot_tracker u_tracker (
    .CLK      (CLK),
    .nRST     (nRST),
    .fu       (fu),
    .port_a   (port_a),
    .port_b   (port_b),
    .dispatch (dispatch),
    .conflict (conflict)
  );

  dispatch_latch u_latch (
    .CLK            (CLK),
    .nRST           (nRST),
    .in_valid       (in_valid),
    .conflict       (conflict),
    .out_ready      (out_ready),
    .fu             (fu),
    .alu_op         (alu_op),
    .funct3         (funct3),
    .rd             (rd),
    .wen            (wen),
    .port_a         (port_a),
    .port_b         (port_b),
    .store_data     (store_data),
    .pc             (in_pc),
    .illegal        (illegal),
    .in_ready       (in_ready),
    .dispatch       (dispatch),
    .out_valid      (out_valid),
    .out_fu         (out_fu),
    .out_alu_op     (out_alu_op),
    .out_funct3     (out_funct3),
    .out_rd         (out_rd),
    .out_wen        (out_wen),
    .out_port_a     (out_port_a),
    .out_port_b     (out_port_b),
    .out_store_data (out_store_data),
    .out_pc         (out_pc),
    .out_illegal    (out_illegal)
  );

endmodule

`default_nettype wire

/* tests/tb_decode_stage.sv */
// testbench for the decode stage with random instructions, a reference model and a scoreboard
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage;

  localparam int NUM_INSTR    = 400;
  localparam int RESET_CYCLES = 10;

  typedef struct packed {
    decode_pkg::fu_t         fu;
    decode_pkg::alu_op_t     alu_op;
    logic [2:0]              funct3;
    rv32_isa_pkg::reg_addr_t rd;
    logic                    wen;
    rv32_isa_pkg::word_t     port_a;
    rv32_isa_pkg::word_t     port_b;
    rv32_isa_pkg::word_t     store_data;
    rv32_isa_pkg::word_t     pc;
    logic                    illegal;
  } exp_t;

  logic                    CLK;
  logic                    nRST;
  logic                    in_valid;
  rv32_isa_pkg::word_t     in_instr;
  rv32_isa_pkg::word_t     in_pc;
  logic                    in_ready;
  rv32_isa_pkg::reg_addr_t rs1_addr;
  rv32_isa_pkg::reg_addr_t rs2_addr;
  rv32_isa_pkg::word_t     rs1_data;
  rv32_isa_pkg::word_t     rs2_data;
  logic                    rs1_bypass_ena;
  rv32_isa_pkg::word_t     rs1_bypass_data;
  logic                    rs2_bypass_ena;
  rv32_isa_pkg::word_t     rs2_bypass_data;
  logic                    out_valid;
  decode_pkg::fu_t         out_fu;
  decode_pkg::alu_op_t     out_alu_op;
  logic [2:0]              out_funct3;
  rv32_isa_pkg::reg_addr_t out_rd;
  logic                    out_wen;
  rv32_isa_pkg::word_t     out_port_a;
  rv32_isa_pkg::word_t     out_port_b;
  rv32_isa_pkg::word_t     out_store_data;
  rv32_isa_pkg::word_t     out_pc;
  logic                    out_illegal;
  logic                    out_ready;

  integer seed;
  int     cyc = 0;
  int     cyc_limit;
  int     div_count = 0;
  int     fast_divs = 0;
  int     delivered = 0;
  // instructions accepted by the DUT
  int     sent_count = 0;
  int     checks_run [1:5];
  int     errs [1:5];
  string  test_name [1:5];
  exp_t   expq [$];
  bit     reserved [int];
  exp_t   snapshot;
  logic   hold_pending = 1'b0;
  logic   will_accept = 1'b0;
  logic   seen_first = 1'b0;
  logic   first_pending = 1'b0;

  decode_stage uut (.*);

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  always @(posedge CLK) cyc <= cyc + 1;

  function automatic logic [31:0] rnd();
    rnd = $random(seed);
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    return rnd() % n;
  endfunction

  function automatic decode_pkg::alu_op_t alu_from(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0:    alu_from = alt ? decode_pkg::ALU_SUB : decode_pkg::ALU_ADD;
      3'd1:    alu_from = decode_pkg::ALU_SLL;
      3'd2:    alu_from = decode_pkg::ALU_SLT;
      3'd3:    alu_from = decode_pkg::ALU_SLTU;
      3'd4:    alu_from = decode_pkg::ALU_XOR;
      3'd5:    alu_from = alt ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL;
      3'd6:    alu_from = decode_pkg::ALU_OR;
      default: alu_from = decode_pkg::ALU_AND;
    endcase
  endfunction

  // expected decode from the isa rules, r1 and r2 already bypassed
  function automatic exp_t model_decode(input logic [31:0] ins, input logic [31:0] pc,
                                        input logic [31:0] r1, input logic [31:0] r2);
    exp_t       e;
    logic [6:0] f7;
    logic [2:0] f3;
    logic       shift;
    f7 = ins[31:25];
    f3 = ins[14:12];
    e = '0;
    e.fu = decode_pkg::FU_NONE;
    e.alu_op = decode_pkg::ALU_ADD;
    e.funct3 = f3;
    e.rd = ins[11:7];
    e.pc = pc;
    e.port_a = r1;
    e.port_b = r2;
    e.store_data = r2;
    case (ins[6:0])
      rv32_isa_pkg::OP: begin
        if (f7 == rv32_isa_pkg::FUNCT7_MULDIV) begin
          e.fu = f3[2] ? decode_pkg::FU_DIV : decode_pkg::FU_MUL;
        end else if (f7 == 7'b0 ||
                     (f7 == rv32_isa_pkg::FUNCT7_ALT && (f3 == 3'b000 || f3 == 3'b101))) begin
          e.fu = decode_pkg::FU_ALU;
          e.alu_op = alu_from(f3, f7 == rv32_isa_pkg::FUNCT7_ALT);
        end else begin
          e.illegal = 1'b1;
        end
      end
      rv32_isa_pkg::OP_IMM: begin
        e.port_b = 32'($signed(ins[31:20]));
        shift = (f3 == 3'b001 || f3 == 3'b101);
        if (shift && !(f7 == 7'b0 || (f3 == 3'b101 && f7 == rv32_isa_pkg::FUNCT7_ALT))) begin
          e.illegal = 1'b1;
        end else begin
          e.fu = decode_pkg::FU_ALU;
          e.alu_op = alu_from(f3, shift && f7 == rv32_isa_pkg::FUNCT7_ALT);
        end
      end
      rv32_isa_pkg::LUI: begin
        e.fu = decode_pkg::FU_ALU;
        e.alu_op = decode_pkg::ALU_COPY_B;
        e.port_b = {ins[31:12], 12'h000};
      end
      rv32_isa_pkg::AUIPC: begin
        e.fu = decode_pkg::FU_ALU;
        e.port_a = pc;
        e.port_b = {ins[31:12], 12'h000};
      end
      rv32_isa_pkg::LOAD: begin
        e.fu = decode_pkg::FU_LSU;
        e.port_b = 32'($signed(ins[31:20]));
      end
      rv32_isa_pkg::STORE: begin
        e.fu = decode_pkg::FU_LSU;
        e.port_b = 32'($signed({ins[31:25], ins[11:7]}));
      end
      default: e.illegal = 1'b1;
    endcase
    e.wen = !e.illegal && ins[6:0] != rv32_isa_pkg::STORE && e.rd != 5'd0;
    return e;
  endfunction

  // writeback slot, -1 when the instruction reserves none
  function automatic int slot_latency(input exp_t e);
    case (e.fu)
      decode_pkg::FU_ALU: return int'(decode_pkg::LAT_ALU);
      decode_pkg::FU_MUL: return int'(decode_pkg::LAT_MUL);
      decode_pkg::FU_DIV: begin
        if (e.port_a == decode_pkg::DIV_MIN_INT || e.port_b == '1 || e.port_b == '0) begin
          return int'(decode_pkg::LAT_DIV_FAST);
        end
        return int'(decode_pkg::LAT_DIV);
      end
      default: return -1;
    endcase
  endfunction

  function automatic exp_t capture_out();
    exp_t o;
    o.fu = out_fu;
    o.alu_op = out_alu_op;
    o.funct3 = out_funct3;
    o.rd = out_rd;
    o.wen = out_wen;
    o.port_a = out_port_a;
    o.port_b = out_port_b;
    o.store_data = out_store_data;
    o.pc = out_pc;
    o.illegal = out_illegal;
    return o;
  endfunction

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] exp, input int t);
    checks_run[t]++;
    assert (got === exp) else begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      errs[t]++;
    end
  endtask

  task automatic report_test(input int t);
    $display("test %0d %s: %0d checks, %0d errors", t, test_name[t], checks_run[t], errs[t]);
  endtask

  task automatic compare_out(input exp_t e);
    int t;
    t = (e.illegal || e.fu == decode_pkg::FU_LSU) ? 3 : 2;
    check_field("out_fu", out_fu, e.fu, t);
    check_field("out_illegal", out_illegal, e.illegal, t);
    check_field("out_rd", out_rd, e.rd, t);
    check_field("out_wen", out_wen, e.wen, t);
    check_field("out_pc", out_pc, e.pc, t);
    check_field("out_funct3", out_funct3, e.funct3, t);
    if (!e.illegal) begin
      if (e.fu == decode_pkg::FU_ALU) begin
        check_field("out_alu_op", out_alu_op, e.alu_op, t);
      end
      check_field("out_port_a", out_port_a, e.port_a, t);
      check_field("out_port_b", out_port_b, e.port_b, t);
      check_field("out_store_data", out_store_data, e.store_data, t);
    end
  endtask

  // weighted pick over the kept opcodes, with a tail of illegal words
  task automatic drive_new_instruction();
    logic [31:0]  ins;
    int unsigned  pick;
    logic [2:0]   f3;
    ins = rnd();
    f3 = ins[14:12];
    pick = rand_below(100);
    in_pc = rnd() & 32'hffff_fffc;
    rs1_data = rnd();
    rs2_data = rnd();
    rs1_bypass_ena = rand_below(2) == 1;
    rs1_bypass_data = rnd();
    rs2_bypass_ena = rand_below(2) == 1;
    rs2_bypass_data = rnd();
    if (pick < 20) begin
      ins[6:0] = rv32_isa_pkg::OP;
      ins[31:25] = 7'b0;
      if ((f3 == 3'b000 || f3 == 3'b101) && rand_below(2) == 1) begin
        ins[31:25] = rv32_isa_pkg::FUNCT7_ALT;
      end
    end else if (pick < 35) begin
      ins[6:0] = rv32_isa_pkg::OP_IMM;
      if (f3 == 3'b001) begin
        ins[31:25] = 7'b0;
      end else if (f3 == 3'b101) begin
        ins[31:25] = rand_below(2) ? rv32_isa_pkg::FUNCT7_ALT : 7'b0;
      end
    end else if (pick < 43) begin
      ins[6:0] = rv32_isa_pkg::LUI;
    end else if (pick < 51) begin
      ins[6:0] = rv32_isa_pkg::AUIPC;
    end else if (pick < 62) begin
      ins[6:0] = rv32_isa_pkg::LOAD;
      ins[14:12] = 3'b010;
    end else if (pick < 72) begin
      ins[6:0] = rv32_isa_pkg::STORE;
      ins[14:12] = 3'b010;
    end else if (pick < 84) begin
      ins[6:0] = rv32_isa_pkg::OP;
      ins[31:25] = rv32_isa_pkg::FUNCT7_MULDIV;
      ins[14] = 1'b0;
    end else if (pick < 93) begin
      ins[6:0] = rv32_isa_pkg::OP;
      ins[31:25] = rv32_isa_pkg::FUNCT7_MULDIV;
      ins[14] = 1'b1;
      div_count++;
      cyc_limit = 4 * NUM_INSTR + RESET_CYCLES + int'(decode_pkg::WB_SLOTS) * div_count;
      // overflow, divide by -1 and divide by zero operands
      case (rand_below(5))
        0: begin
          rs1_bypass_ena = 1'b1;
          rs1_bypass_data = decode_pkg::DIV_MIN_INT;
        end
        1: begin
          rs2_bypass_ena = 1'b1;
          rs2_bypass_data = '1;
        end
        2: begin
          rs2_bypass_ena = 1'b0;
          rs2_data = '0;
        end
        default: ;
      endcase
    end else begin
      case (rand_below(3))
        0: begin
          ins[6:0] = rv32_isa_pkg::OP;
          ins[31:25] = 7'b1111111;
        end
        1: begin
          ins[6:0] = rv32_isa_pkg::OP_IMM;
          ins[14:12] = 3'b001;
          ins[31:25] = 7'b0010000;
        end
        default: ins[6:0] = rand_below(2) ? 7'b1101111 : 7'b1110011;
      endcase
    end
    in_instr = ins;
  endtask

  // sampled mid-cycle, so everything here decides the next rising edge
  always @(negedge CLK) begin : monitor
    exp_t cur;
    exp_t head;
    int   lat;
    logic conf;
    logic exp_ready;
    if (nRST) begin
      cur = model_decode(in_instr, in_pc,
                         rs1_bypass_ena ? rs1_bypass_data : rs1_data,
                         rs2_bypass_ena ? rs2_bypass_data : rs2_data);
      lat = slot_latency(cur);
      conf = (lat >= 0) && reserved.exists(cyc + 1 + lat);
      exp_ready = (expq.size() == 0 || out_ready) && !conf;
      if (first_pending) begin
        check_field("out_valid", out_valid, 1'b1, 1);
        report_test(1);
        first_pending = 1'b0;
      end
      check_field("out_valid", out_valid, expq.size() != 0, 4);
      check_field("in_ready", in_ready, exp_ready, conf ? 5 : 4);
      if (hold_pending) begin
        checks_run[4]++;
        assert (capture_out() === snapshot) else begin
          $display("[ERROR] out payload got %h expected %h", capture_out(), snapshot);
          errs[4]++;
        end
      end
      hold_pending = out_valid && !out_ready;
      snapshot = capture_out();
      if (out_valid && out_ready) begin
        checks_run[4]++;
        assert (expq.size() != 0) else begin
          $display("output transfer with no accepted instruction waiting");
          errs[4]++;
        end
        if (expq.size() != 0) begin
          head = expq.pop_front();
          compare_out(head);
        end
        delivered++;
      end
      if (in_valid && in_ready) begin
        expq.push_back(cur);
        check_field("rs1_addr", rs1_addr, in_instr[19:15], 2);
        check_field("rs2_addr", rs2_addr, in_instr[24:20], 2);
        if (cur.fu == decode_pkg::FU_DIV && lat == int'(decode_pkg::LAT_DIV_FAST)) begin
          fast_divs++;
        end
        if (lat >= 0) begin
          checks_run[5]++;
          assert (!reserved.exists(cyc + 1 + lat)) else begin
            $display("writeback cycle %0d was already taken by an earlier instruction",
                     cyc + 1 + lat);
            errs[5]++;
          end
          reserved[cyc + 1 + lat] = 1'b1;
        end
        if (!seen_first) begin
          seen_first = 1'b1;
          first_pending = 1'b1;
        end
      end
      will_accept = in_valid && in_ready;
    end
  end

  initial begin : watchdog
    wait (cyc > cyc_limit);
    $display("timeout, run did not finish within %0d cycles", cyc_limit);
    $display("TEST FAILED");
    $finish;
  end

  initial begin : main
    int total_checks;
    int total_errs;
    seed = 32'h9f35;
    cyc_limit = 4 * NUM_INSTR + RESET_CYCLES;
    test_name[1] = "reset state";
    test_name[2] = "alu and muldiv decode";
    test_name[3] = "load/store and illegal decode";
    test_name[4] = "back-pressure ordering";
    test_name[5] = "writeback slots";
    for (int t = 1; t <= 5; t++) begin
      checks_run[t] = 0;
      errs[t] = 0;
    end
    nRST = 1'b0;
    in_valid = 1'b0;
    in_instr = '0;
    in_pc = '0;
    rs1_data = '0;
    rs2_data = '0;
    rs1_bypass_ena = 1'b0;
    rs1_bypass_data = '0;
    rs2_bypass_ena = 1'b0;
    rs2_bypass_data = '0;
    out_ready = 1'b0;
    repeat (RESET_CYCLES) begin
      @(negedge CLK);
      check_field("out_valid", out_valid, 1'b0, 1);
    end
    @(posedge CLK);
    #10 nRST = 1'b1;
    @(negedge CLK);
    check_field("out_valid", out_valid, 1'b0, 1);
    while (delivered < NUM_INSTR) begin
      @(posedge CLK);
      #10;
      // hold the payload until it has been taken
      if (will_accept || !in_valid) begin
        if (rand_below(10) < 8 && sent_count < NUM_INSTR) begin
          drive_new_instruction();
          in_valid = 1'b1;
        end else begin
          in_valid = 1'b0;
        end
      end
      out_ready = rand_below(10) < 7;
    end
    for (int t = 2; t <= 5; t++) begin
      report_test(t);
    end
    total_checks = 0;
    total_errs = 0;
    for (int t = 1; t <= 5; t++) begin
      total_checks += checks_run[t];
      total_errs += errs[t];
    end
    $display("%0d instructions, %0d fast divides, %0d checks, %0d errors",
             delivered, fast_divs, total_checks, total_errs);
    if (total_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  always @(posedge CLK) begin
    if (nRST && will_accept) begin
      sent_count <= sent_count + 1;
    end
  end

endmodule

`default_nettype wire

/* tb.f */
hw/rv32_isa_pkg.sv
hw/decode_pkg.sv
hw/instr_decoder.sv
hw/operand_select.sv
hw/wb_slot_tracker.sv
hw/dispatch_latch.sv
hw/decode_stage.sv
tests/tb_decode_stage.sv

/* Bender.yml */
package:
  name: decode_stage

sources:
  - files:
      - hw/rv32_isa_pkg.sv
      - hw/decode_pkg.sv
      - hw/instr_decoder.sv
      - hw/operand_select.sv
      - hw/wb_slot_tracker.sv
      - hw/dispatch_latch.sv
      - hw/decode_stage.sv
  - target: test
    files:
      - tests/tb_decode_stage.sv
